// File: files.f
+incdir+source
source/gmii_pkg.sv
source/axis_pkg.sv
source/gmii_rx_framer.sv
source/axis_error_filter.sv
source/gmii_rx_mac.sv
tb/gmii_rx_mac_tb.sv

// File: Bender.yml
package:
  name: gmii_rx_mac

sources:
  - include_dirs:
      - source
    files:
      - source/gmii_pkg.sv
      - source/axis_pkg.sv
      - source/gmii_rx_framer.sv
      - source/axis_error_filter.sv
      - source/gmii_rx_mac.sv
  - target: test
    include_dirs:
      - source
    files:
      - tb/gmii_rx_mac_tb.sv

// File: tb/gmii_rx_mac_tests.txt
# B record: name B line_byte_count line_bytes(hex) rxer_index(-1 none) word_count
#   then data(hex) keep(hex) last for each expected output word
# L record: name L payload_length expect(1 delivered, 0 dropped)
#   the line is 7x 55, d5, then the payload from the LFSR seeded 76

# Good frames with an even and an odd payload
even_payload  B 14
  55 55 55 55 55 55 55 d5 01 02 03 04 05 06
  -1 3  0201 3 0  0403 3 0  0605 3 1
odd_payload  B 13
  55 55 55 55 55 55 55 d5 11 22 33 44 55
  -1 3  2211 3 0  4433 3 0  0055 1 1

# rxer on line byte 11 drops the whole frame, the next one is intact
rxer_mid  B 16
  55 55 55 55 55 55 55 d5 a0 a1 a2 a3 a4 a5 a6 a7
  11 0
after_rxer  B 12
  55 55 55 55 55 55 55 d5 c1 c2 c3 c4
  -1 2  c2c1 3 0  c4c3 3 1

# Broken preambles give no output and leave the next frame alone
bad_first  B 10
  54 55 55 55 55 55 55 d5 01 02
  -1 0
after_bad_first  B 11
  55 55 55 55 55 55 55 d5 e1 e2 e3
  -1 2  e2e1 3 0  00e3 1 1
bad_before_sfd  B 12
  55 55 55 33 55 55 55 d5 01 02 03 04
  -1 0
after_bad_sfd  B 10
  55 55 55 d5 f0 f1 f2 f3 f4 f5
  -1 3  f1f0 3 0  f3f2 3 0  f5f4 3 1

# Too long for the 128 byte FIFO, then frames at the minimum gap
overflow_drop  L 160 0
burst_a  L 40 1
burst_b  L 61 1
burst_c  L 52 1

// File: tb/gmii_rx_mac_tb.sv
/*
 * Testbench for the gigabit Ethernet receive MAC
 * Replays GMII frames from a test file and checks the stream words that leave
 */

`timescale 1ns/1ns
`include "eth_macros.svh"

module gmii_rx_mac_tb;
	import gmii_pkg::*;
	import axis_pkg::*;

	localparam int BYTES     = `ETH_AXIS_BYTES;
	localparam int MAX_TESTS = 32;
	localparam int GAP       = 12;

	logic               eth_clk;
	logic               eth_sresetn;
	gmii_byte_t         gmii_rxd;
	logic               gmii_rxdv;
	logic               gmii_rxer;
	logic               axis_tvalid;
	logic [8*BYTES-1:0] axis_tdata;
	keep_t              axis_tkeep;
	logic               axis_tlast;
	rx_state_t          framer_state;

	// Test records, with the line bytes of all tests in one queue
	string              name [MAX_TESTS];
	int                 line_start [MAX_TESTS];
	int                 line_len [MAX_TESTS];
	int                 rxer_at [MAX_TESTS];
	int                 want [MAX_TESTS];
	int                 got [MAX_TESTS];
	int                 errs [MAX_TESTS];
	logic [7:0]         line_q [$];

	// Expected output words in arrival order, each tagged with its test
	logic [8*BYTES-1:0] exp_data [$];
	keep_t              exp_keep [$];
	logic               exp_last [$];
	int                 exp_test [$];

	int fd;
	int ntests;
	int driving;
	int driven;
	int waiting;
	int errors;
	int passed;
	int failed;
	int cycles;
	int limit;

	gmii_rx_mac dut0
	(
		.i_eth_clk(eth_clk),
		.i_eth_sresetn(eth_sresetn),
		.i_gmii_rxd(gmii_rxd),
		.i_gmii_rxdv(gmii_rxdv),
		.i_gmii_rxer(gmii_rxer),
		.o_axis_tvalid(axis_tvalid),
		.o_axis_tdata(axis_tdata),
		.o_axis_tkeep(axis_tkeep),
		.o_axis_tlast(axis_tlast)
	);

	// Framer state, shown when the run times out
	assign framer_state = dut0.framer0.state;

	initial
	begin
		eth_clk = 1'b0;
		forever
			#10 eth_clk = ~eth_clk;
	end

	// Galois LFSR with taps 16, 14, 13 and 11, one step per payload bit
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// Data bits that a keep mask marks as frame bytes
	function automatic logic [8*BYTES-1:0] lane_mask(input keep_t k);
		logic [8*BYTES-1:0] m;
		int                 i;
		m = '0;
		for (i = 0; i < BYTES; i++)
			if (k[i])
				m[8*i +: 8] = 8'hFF;
		return m;
	endfunction

	// Next word of the test file, a # comment runs to the end of its line
	task automatic read_token(output string tok, output bit ok);
		string rest;
		int    n;
		ok = 1'b0;
		forever
		begin
			n = $fscanf(fd, "%s", tok);
			if (n != 1)
				return;
			if (tok.substr(0, 0) != "#")
				break;
			n = $fgets(rest, fd);
		end
		ok = 1'b1;
	endtask

	task automatic read_number(input bit hex, output int v);
		string tok;
		bit    ok;
		int    n;
		v = 0;
		read_token(tok, ok);
		if (!ok)
		begin
			$display("test file ends in the middle of record %0d", ntests);
			errors++;
		end
		else if (hex)
			n = $sscanf(tok, "%h", v);
		else
			n = $sscanf(tok, "%d", v);
	endtask

	task automatic add_expected(input logic [8*BYTES-1:0] d, input keep_t k, input logic l);
		exp_data.push_back(d);
		exp_keep.push_back(k);
		exp_last.push_back(l);
		exp_test.push_back(ntests);
		want[ntests]++;
	endtask

	// Reads every record and builds the line bytes and the expected words
	task automatic load_tests();
		string              tok;
		bit                 ok;
		int                 i;
		int                 k;
		int                 cnt;
		int                 v;
		int                 keep;
		int                 last;
		logic [15:0]        lfsr;
		logic [7:0]         b;
		logic [8*BYTES-1:0] word;
		keep_t              wkeep;
		lfsr = 16'd76;
		fd = $fopen("tb/gmii_rx_mac_tests.txt", "r");
		if (fd == 0)
		begin
			$display("cannot open the test file tb/gmii_rx_mac_tests.txt");
			errors++;
			return;
		end
		forever
		begin
			read_token(tok, ok);
			if (!ok || ntests == MAX_TESTS)
				break;
			name[ntests] = tok;
			line_start[ntests] = line_q.size();
			rxer_at[ntests] = -1;
			read_token(tok, ok);
			read_number(1'b0, cnt);
			if (tok == "L")
			begin
				read_number(1'b0, v);
				for (i = 0; i < 7; i++)
					line_q.push_back(`ETH_PREAMBLE_BYTE);
				line_q.push_back(`ETH_SFD_BYTE);
				for (i = 0; i < cnt; i++)
				begin
					for (k = 0; k < 8; k++)
					begin
						b[k] = lfsr[0];
						lfsr = lfsr_step(lfsr);
					end
					line_q.push_back(b);
					// Payload byte i goes to lane i mod BYTES, the frame's last byte closes a word
					if (i % BYTES == 0)
					begin
						word = '0;
						wkeep = '0;
					end
					word[8*(i % BYTES) +: 8] = b;
					wkeep[i % BYTES] = 1'b1;
					if (v != 0 && (i % BYTES == BYTES - 1 || i == cnt - 1))
						add_expected(word, wkeep, i == cnt - 1);
				end
			end
			else
			begin
				for (i = 0; i < cnt; i++)
				begin
					read_number(1'b1, v);
					line_q.push_back(v[7:0]);
				end
				read_number(1'b0, rxer_at[ntests]);
				read_number(1'b0, cnt);
				for (i = 0; i < cnt; i++)
				begin
					read_number(1'b1, v);
					read_number(1'b1, keep);
					read_number(1'b0, last);
					add_expected(v[8*BYTES-1:0], keep[BYTES-1:0], last != 0);
				end
			end
			line_len[ntests] = line_q.size() - line_start[ntests];
			ntests++;
		end
		$fclose(fd);
	endtask

	// Plays the frames in file order, each one followed by the inter-frame gap
	task automatic run_frames();
		int t;
		int i;
		for (t = 0; t < ntests; t++)
		begin
			driving = t;
			for (i = 0; i < line_len[t]; i++)
			begin
				@(posedge eth_clk);
				gmii_rxd  <= line_q[line_start[t] + i];
				gmii_rxdv <= 1'b1;
				gmii_rxer <= (i == rxer_at[t]);
			end
			repeat (GAP)
			begin
				@(posedge eth_clk);
				gmii_rxd  <= 8'h00;
				gmii_rxdv <= 1'b0;
				gmii_rxer <= 1'b0;
			end
			driven = t + 1;
		end
	endtask

	// A test is done once its frame and gap are sent and all its words came out
	task automatic report_tests();
		int t;
		for (t = 0; t < ntests; t++)
		begin
			waiting = t;
			while (driven <= t || got[t] < want[t])
				@(negedge eth_clk);
			if (errs[t] == 0)
			begin
				passed++;
				$display("test %s passed with %0d words", name[t], got[t]);
			end
			else
			begin
				failed++;
				$display("test %s failed with %0d errors", name[t], errs[t]);
			end
		end
		waiting = ntests;
	endtask

	// Output words are stable at the falling edge and are compared there in order
	always @(negedge eth_clk)
	begin : capture
		int t;
		if (eth_sresetn && axis_tvalid)
		begin
			if (exp_data.size() == 0)
			begin
				$display("extra output word %h at %0t when no word was expected",
					axis_tdata, $time);
				errors++;
				errs[driving]++;
			end
			else
			begin
				t = exp_test[0];
				// Lanes outside keep carry no frame data and are not compared
				if (axis_tkeep !== exp_keep[0] || axis_tlast !== exp_last[0] ||
					((axis_tdata ^ exp_data[0]) & lane_mask(exp_keep[0])) !== '0)
				begin
					$display("error at %0t: test %s word %0d is %h/%b/%b, expected %h/%b/%b",
						$time, name[t], got[t], axis_tdata, axis_tkeep, axis_tlast,
						exp_data[0], exp_keep[0], exp_last[0]);
					errors++;
					errs[t]++;
				end
				got[t]++;
				exp_data.delete(0);
				exp_keep.delete(0);
				exp_last.delete(0);
				exp_test.delete(0);
			end
		end
	end

	// The cycle limit comes from the total line time of all tests
	always @(posedge eth_clk)
	begin
		cycles <= cycles + 1;
		if (cycles > limit)
		begin
			$display("timeout after %0d cycles on test %0d of %0d, %0d words never came out",
				cycles, waiting, ntests, exp_data.size());
			$display("framer was in state %s", framer_state.name());
			$display("Simulation FAILED");
			$finish;
		end
	end

	initial
	begin
		eth_sresetn = 1'b0;
		gmii_rxd    = 8'h00;
		gmii_rxdv   = 1'b0;
		gmii_rxer   = 1'b0;
		load_tests();
		limit = 2 * (line_q.size() + GAP * ntests) + 200;
		repeat (4)
			@(posedge eth_clk);
		eth_sresetn <= 1'b1;
		fork
			run_frames();
			report_tests();
		join
		// Stray words from the last frames would still show up here
		repeat (20)
			@(negedge eth_clk);
		$display("%0d tests passed, %0d tests failed, %0d errors", passed, failed, errors);
		if (errors == 0 && failed == 0 && passed > 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

// File: source/gmii_rx_mac.sv
/*
 * Gigabit Ethernet receive MAC
 * GMII framer followed by a frame error filter, all on eth_clk
 */

`timescale 1ns/1ns
`include "eth_macros.svh"

module gmii_rx_mac
(
	input  logic                         i_eth_clk,
	input  logic                         i_eth_sresetn,
	input  gmii_pkg::gmii_byte_t         i_gmii_rxd,
	input  logic                         i_gmii_rxdv,
	input  logic                         i_gmii_rxer,
	output logic                         o_axis_tvalid,
	output logic [8*`ETH_AXIS_BYTES-1:0] o_axis_tdata,
	output axis_pkg::keep_t              o_axis_tkeep,
	output logic                         o_axis_tlast
);
	import axis_pkg::*;

	// Packed words from the framer, one strobe per word
	logic                         frm_valid;
	logic [8*`ETH_AXIS_BYTES-1:0] frm_data;
	keep_t                        frm_keep;
	logic                         frm_last;
	logic                         frm_error;

	gmii_rx_framer
	#(
		.BYTES(`ETH_AXIS_BYTES)
	) framer0 (
		.i_eth_clk(i_eth_clk),
		.i_eth_sresetn(i_eth_sresetn),
		.i_gmii_rxd(i_gmii_rxd),
		.i_gmii_rxdv(i_gmii_rxdv),
		.i_gmii_rxer(i_gmii_rxer),
		.o_valid(frm_valid),
		.o_data(frm_data),
		.o_keep(frm_keep),
		.o_last(frm_last),
		.o_error(frm_error)
	);

	// Holds each frame back until it is known to be complete and error free
	axis_error_filter
	#(
		.BYTES(`ETH_AXIS_BYTES),
		.LOG2_DEPTH(`ETH_FIFO_LOG2_DEPTH)
	) filter0 (
		.i_eth_clk(i_eth_clk),
		.i_eth_sresetn(i_eth_sresetn),
		.i_valid(frm_valid),
		.i_data(frm_data),
		.i_keep(frm_keep),
		.i_last(frm_last),
		.i_error(frm_error),
		.o_axis_tvalid(o_axis_tvalid),
		.o_axis_tdata(o_axis_tdata),
		.o_axis_tkeep(o_axis_tkeep),
		.o_axis_tlast(o_axis_tlast)
	);

endmodule

// File: source/axis_error_filter.sv
/*
 * Frame error filter
 * Buffers each frame in a FIFO and releases it only once it has arrived
 * complete and error free, otherwise the whole frame is rolled back
 */

`timescale 1ns/1ns
`include "eth_macros.svh"

module axis_error_filter
#(
	parameter int BYTES      = `ETH_AXIS_BYTES,
	parameter int LOG2_DEPTH = `ETH_FIFO_LOG2_DEPTH
)
(
	input  logic               i_eth_clk,
	input  logic               i_eth_sresetn,
	input  logic               i_valid,
	input  logic [8*BYTES-1:0] i_data,
	input  axis_pkg::keep_t    i_keep,
	input  logic               i_last,
	input  logic               i_error,
	output logic               o_axis_tvalid,
	output logic [8*BYTES-1:0] o_axis_tdata,
	output axis_pkg::keep_t    o_axis_tkeep,
	output logic               o_axis_tlast
);
	import axis_pkg::*;

	localparam int DEPTH = 1 << LOG2_DEPTH;

	// Word storage, split per field
	logic [8*BYTES-1:0] mem_data [DEPTH];
	keep_t              mem_keep [DEPTH];
	logic               mem_last [DEPTH];

	// Words between rd_ptr and commit_ptr belong to complete good frames
	// Words between commit_ptr and wr_ptr belong to the frame still arriving
	logic [LOG2_DEPTH-1:0] wr_ptr;
	logic [LOG2_DEPTH-1:0] commit_ptr;
	logic [LOG2_DEPTH-1:0] rd_ptr;
	filter_state_t         state;
	logic                  full;
	logic                  wr_en;

	always_comb
	begin
		// One slot stays free so that equal pointers always mean empty
		full  = ((wr_ptr + 1'b1) == rd_ptr);
		wr_en = i_valid && (state == ACCEPT) && !i_error && !full;
	end

	always_ff @(posedge i_eth_clk)
	begin
		if (wr_en)
		begin
			mem_data[wr_ptr] <= i_data;
			mem_keep[wr_ptr] <= i_keep;
			mem_last[wr_ptr] <= i_last;
		end
	end

	// Write side, with commit on a good last word and rollback otherwise
	always_ff @(posedge i_eth_clk)
	begin
		if (!i_eth_sresetn)
		begin
			state      <= ACCEPT;
			wr_ptr     <= '0;
			commit_ptr <= '0;
		end
		else if (i_valid)
		begin
			case (state)
				ACCEPT:
				begin
					if (i_error)
					begin
						// Errored frame, forget every word stored for it
						wr_ptr <= commit_ptr;
					end
					else if (full)
					begin
						// Frame does not fit, drop what is stored and skip the rest
						wr_ptr <= commit_ptr;
						if (!i_last)
							state <= DISCARD;
					end
					else
					begin
						wr_ptr <= wr_ptr + 1'b1;
						if (i_last)
							commit_ptr <= wr_ptr + 1'b1;
					end
				end

				DISCARD:
				begin
					// The last word of the dropped frame is dropped as well
					if (i_last)
						state <= ACCEPT;
				end

				default:
					state <= ACCEPT;
			endcase
		end
	end

	// Read side emits one committed word per cycle with no back-pressure
	assign o_axis_tvalid = (rd_ptr != commit_ptr);
	assign o_axis_tdata  = mem_data[rd_ptr];
	assign o_axis_tkeep  = mem_keep[rd_ptr];
	assign o_axis_tlast  = mem_last[rd_ptr];

	always_ff @(posedge i_eth_clk)
	begin
		if (!i_eth_sresetn)
			rd_ptr <= '0;
		else if (o_axis_tvalid)
			rd_ptr <= rd_ptr + 1'b1;
	end

endmodule

// File: source/gmii_rx_framer.sv
/*
 * GMII receive framer
 * Registers the line, checks the preamble and SFD, strips them and packs
 * the frame bytes into stream words with keep, last and error flags
 */

`timescale 1ns/1ns
`include "eth_macros.svh"

module gmii_rx_framer
#(
	parameter int BYTES = `ETH_AXIS_BYTES
)
(
	input  logic                 i_eth_clk,
	input  logic                 i_eth_sresetn,
	input  gmii_pkg::gmii_byte_t i_gmii_rxd,
	input  logic                 i_gmii_rxdv,
	input  logic                 i_gmii_rxer,
	output logic                 o_valid,
	output logic [8*BYTES-1:0]   o_data,
	output axis_pkg::keep_t      o_keep,
	output logic                 o_last,
	output logic                 o_error
);
	import gmii_pkg::*;
	import axis_pkg::*;

	localparam int                LANE_W   = (BYTES > 1) ? $clog2(BYTES) : 1;
	localparam logic [LANE_W-1:0] LANE_MAX = LANE_W'(BYTES - 1);

	gmii_byte_t         rx_data;
	logic               rx_dv;
	logic               rx_er;
	rx_state_t          state;
	logic [LANE_W-1:0]  lane;
	keep_t              keep_acc;
	keep_t              keep_next;
	logic [8*BYTES-1:0] word_next;
	logic               word_full;
	logic               last_byte;
	logic               strobe;

	// One register stage on the line, the FSM works on the registered byte
	always_ff @(posedge i_eth_clk)
	begin
		rx_data <= i_gmii_rxd;
		if (!i_eth_sresetn)
		begin
			rx_dv <= 1'b0;
			rx_er <= 1'b0;
		end
		else
		begin
			rx_dv <= i_gmii_rxdv;
			rx_er <= i_gmii_rxer;
		end
	end

	always_comb
	begin
		// A new word starts from zero so unused lanes read as zero
		word_next = (lane == '0) ? '0 : o_data;
		word_next[int'(lane) * 8 +: 8] = rx_data;
		keep_next = keep_acc | (keep_t'(1) << lane);
		word_full = (lane == LANE_MAX);
		// The live line is one byte ahead, so it already tells whether the
		// registered byte is the final one of the frame
		last_byte = !i_gmii_rxdv;
		strobe    = word_full || last_byte || rx_er;
	end

	always_ff @(posedge i_eth_clk)
	begin
		if (!i_eth_sresetn)
		begin
			state    <= WAIT_IDLE;
			lane     <= '0;
			keep_acc <= '0;
			o_valid  <= 1'b0;
		end
		else
		begin
			o_valid <= 1'b0;
			case (state)
				// Only an idle line guarantees the next valid byte opens a frame
				WAIT_IDLE:
				begin
					if (!rx_dv)
						state <= PREAMBLE;
				end

				// The first valid byte must be preamble
				PREAMBLE:
				begin
					if (rx_dv)
						state <= (rx_data == GMII_PREAMBLE) ? SFD : WAIT_IDLE;
				end

				// More preamble is allowed until the SFD, anything else aborts
				SFD:
				begin
					if (!rx_dv)
						state <= WAIT_IDLE;
					else if (rx_data == GMII_SFD)
						state <= PAYLOAD;
					else if (rx_data != GMII_PREAMBLE)
						state <= WAIT_IDLE;
				end

				PAYLOAD:
				begin
					if (!rx_dv)
					begin
						// Frame stopped right after the SFD, there is nothing to send
						state <= PREAMBLE;
					end
					else
					begin
						o_data  <= word_next;
						o_keep  <= keep_next;
						o_last  <= last_byte || rx_er;
						o_error <= rx_er;
						if (strobe)
						begin
							o_valid  <= 1'b1;
							lane     <= '0;
							keep_acc <= '0;
						end
						else
						begin
							lane     <= lane + 1'b1;
							keep_acc <= keep_next;
						end
						// After rxer the line may still carry frame bytes, so wait for idle
						if (rx_er)
							state <= WAIT_IDLE;
						else if (last_byte)
							state <= PREAMBLE;
					end
				end

				default:
					state <= WAIT_IDLE;
			endcase
		end
	end

endmodule

// File: source/axis_pkg.sv
/*
 * Stream-side types
 * Keep mask of an output word and the error filter write-side states
 */

`include "eth_macros.svh"

package axis_pkg;

	// One bit per byte lane of a stream word, set where the lane holds frame data
	typedef logic [`ETH_AXIS_BYTES-1:0] keep_t;

	// ACCEPT stores words of the current frame
	// DISCARD drops the rest of a frame that overflowed the FIFO
	typedef enum logic
	{
		ACCEPT,
		DISCARD
	} filter_state_t;

endpackage

// File: source/gmii_pkg.sv
/*
 * GMII line-side types
 * Line byte type, framing byte constants and the framer state encoding
 */

`include "eth_macros.svh"

package gmii_pkg;

	// One byte as it appears on the GMII receive data lines
	typedef logic [7:0] gmii_byte_t;

	// Framing bytes that precede the destination address
	localparam gmii_byte_t GMII_PREAMBLE = `ETH_PREAMBLE_BYTE;
	localparam gmii_byte_t GMII_SFD      = `ETH_SFD_BYTE;

	// Framer states, from waiting on an idle line up to passing payload
	typedef enum logic [1:0]
	{
		WAIT_IDLE,
		PREAMBLE,
		SFD,
		PAYLOAD
	} rx_state_t;

endpackage

// File: source/eth_macros.svh
/*
 * Ethernet receive MAC build constants
 * Stream word width, frame FIFO depth and GMII line framing bytes
 */

`ifndef ETH_MACROS_SVH
`define ETH_MACROS_SVH

// Number of frame bytes carried by one output stream word
`define ETH_AXIS_BYTES 2

// The frame FIFO holds 2**N words, so 64 words of 2 bytes give 128 bytes
`define ETH_FIFO_LOG2_DEPTH 6

// Every GMII frame starts with a run of preamble bytes
`define ETH_PREAMBLE_BYTE 8'h55

// The start-of-frame delimiter closes the preamble
`define ETH_SFD_BYTE 8'hD5

`endif
